/* Makefile */
# Verilator flow for the DRAM traffic generator

VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= tb_traffic_generator
RTL_TOP   ?= traffic_generator
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Simulation completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

# pass only if the testbench printed its pass line
run: build
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* common/dram_ctrl_pkg.sv */
package dram_ctrl_pkg;

    // burst addressed memory, one 128 bit word per burst
    localparam int addr_width = 24;   // {row, bank, col}
    localparam int data_width = 128;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;

    // who asked for a memory request
    typedef enum logic [1:0] {
        src_write = 2'd0,
        src_audio = 2'd1,
        src_video = 2'd2
    } src_t;

    // one arbitrated request on its way to the memory bus
    typedef struct packed {
        logic  we;     // 1 = write, 0 = read
        src_t  src;
        addr_t addr;
        data_t data;   // write data, don't care for reads
        logic  last;   // closes the sample load burst
    } mem_req_t;

    // outstanding request queue depth
    localparam int default_max_outstanding = 4;

endpackage

/* common/mem_issue_if.sv */
interface mem_issue_if;
    import dram_ctrl_pkg::*;

    logic     valid;   // decode has a request waiting
    mem_req_t req;     // stable while valid and not ready
    logic     ready;   // execute takes it this cycle
    logic     full;    // no room for another outstanding request

    // decode side
    modport producer (
        output valid,
        output req,
        input  ready
    );

    // execute side, also gated by the queue state
    modport consumer (
        input  valid,
        input  req,
        input  full,
        output ready
    );

    // result side reports queue occupancy
    modport status (
        output full
    );

endinterface

/* tb.f */
common/dram_ctrl_pkg.sv
common/mem_issue_if.sv
traffic/traffic_decode.sv
traffic/traffic_execute.sv
traffic/traffic_result.sv
verilog/traffic_generator.sv
tb/tb_wb_memory.sv
tb/tb_traffic_generator.sv

/* tb/tb_traffic_generator.sv */
module tb_traffic_generator;
    timeunit 1ns;
    timeprecision 1ps;
    import dram_ctrl_pkg::*;

    // below the longest ack latency so the queue limit is reached
    localparam int max_outstanding   = 2;
    localparam int handshake_timeout = 1000;
    localparam int drain_timeout     = 1000;
    localparam int n_extra_writes    = 20;
    localparam int n_reads           = 30;

    logic  clk_dram_ctrl;
    logic  rst_dram_ctrl;
    logic  wr_valid;
    logic  wr_ready;
    addr_t wr_addr;
    data_t wr_data;
    logic  wr_last;
    logic  aud_valid;
    logic  aud_ready;
    addr_t aud_addr;
    logic  vid_valid;
    logic  vid_ready;
    addr_t vid_addr;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    logic  mem_stall;
    logic  mem_ack;
    data_t mem_rdata;
    logic  audio_valid;
    data_t audio_data;
    logic  video_valid;
    data_t video_data;
    logic  load_complete;

    // reference model
    data_t    shadow [addr_t];
    addr_t    burst_addr [$];
    mem_req_t xfer_q [$];      // accepted at the inputs, not yet on the bus
    mem_req_t ack_q [$];       // taken by the bus, waiting for the ack
    data_t    aud_exp_q [$];
    data_t    vid_exp_q [$];
    logic     lc_exp;
    logic     aud_strobe_exp;
    logic     vid_strobe_exp;
    logic     held;            // bus request stalled at the last edge
    logic     held_we;
    addr_t    held_addr;
    data_t    held_wdata;

    traffic_generator #(
        .max_outstanding (max_outstanding)
    ) u_dut (
        .i_clk_dram_ctrl        (clk_dram_ctrl),
        .i_rst_dram_ctrl        (rst_dram_ctrl),
        .i_wr_valid             (wr_valid),
        .o_wr_ready             (wr_ready),
        .i_wr_addr              (wr_addr),
        .i_wr_data              (wr_data),
        .i_wr_last              (wr_last),
        .i_aud_valid            (aud_valid),
        .o_aud_ready            (aud_ready),
        .i_aud_addr             (aud_addr),
        .i_vid_valid            (vid_valid),
        .o_vid_ready            (vid_ready),
        .i_vid_addr             (vid_addr),
        .o_mem_stb              (mem_stb),
        .o_mem_we               (mem_we),
        .o_mem_addr             (mem_addr),
        .o_mem_wdata            (mem_wdata),
        .i_mem_stall            (mem_stall),
        .i_mem_ack              (mem_ack),
        .i_mem_rdata            (mem_rdata),
        .o_audio_valid          (audio_valid),
        .o_audio_data           (audio_data),
        .o_video_valid          (video_valid),
        .o_video_data           (video_data),
        .o_sample_load_complete (load_complete)
    );

    tb_wb_memory u_memory (
        .i_clk_dram_ctrl (clk_dram_ctrl),
        .i_rst_dram_ctrl (rst_dram_ctrl),
        .i_stb           (mem_stb),
        .i_we            (mem_we),
        .i_addr          (mem_addr),
        .i_wdata         (mem_wdata),
        .o_stall         (mem_stall),
        .o_ack           (mem_ack),
        .o_rdata         (mem_rdata)
    );

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #5 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(string name, data_t got, data_t expected);
        if (got !== expected) begin
            stop_on_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                    $time, name, got, expected));
        end
    endtask

    function automatic data_t random_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // reads only ever target written addresses
    function automatic addr_t pick_addr();
        return burst_addr[$urandom_range(burst_addr.size() - 1, 0)];
    endfunction

    task automatic pause_random();
        repeat ($urandom_range(3, 0)) @(negedge clk_dram_ctrl);
    endtask

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic send_request(src_t s, addr_t a, data_t d, logic last);
        int   waited;
        logic accepted;
        case (s)
            src_write: begin
                wr_valid = 1'b1;
                wr_addr  = a;
                wr_data  = d;
                wr_last  = last;
            end
            src_audio: begin
                aud_valid = 1'b1;
                aud_addr  = a;
            end
            default: begin
                vid_valid = 1'b1;
                vid_addr  = a;
            end
        endcase
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk_dram_ctrl);
            case (s)
                src_write: accepted = wr_ready;
                src_audio: accepted = aud_ready;
                default:   accepted = vid_ready;
            endcase
            waited++;
            if (!accepted && waited > handshake_timeout) begin
                stop_on_error($sformatf("%s request was not accepted within %0d cycles",
                                        s.name(), handshake_timeout));
            end
        end
        @(negedge clk_dram_ctrl);
        case (s)
            src_write: wr_valid = 1'b0;
            src_audio: aud_valid = 1'b0;
            default:   vid_valid = 1'b0;
        endcase
    endtask

    always @(posedge clk_dram_ctrl) begin : monitor
        mem_req_t head;
        if (!rst_dram_ctrl) begin
            // registered outputs against the previous edge
            check_value("o_sample_load_complete", data_t'(load_complete), data_t'(lc_exp));
            check_value("o_audio_valid", data_t'(audio_valid), data_t'(aud_strobe_exp));
            check_value("o_video_valid", data_t'(video_valid), data_t'(vid_strobe_exp));
            if (audio_valid) begin
                check_value("o_audio_data", audio_data, aud_exp_q.pop_front());
            end
            if (video_valid) begin
                check_value("o_video_data", video_data, vid_exp_q.pop_front());
            end

            if (!load_complete) begin
                check_value("o_aud_ready", data_t'(aud_ready), '0);
                check_value("o_vid_ready", data_t'(vid_ready), '0);
            end else begin
                if (vid_valid) begin
                    check_value("o_aud_ready", data_t'(aud_ready), '0);   // video first
                end
                if (vid_valid || aud_valid) begin
                    check_value("o_wr_ready", data_t'(wr_ready), '0);
                end
            end

            // bus request must not move while stalled
            if (held) begin
                check_value("o_mem_stb under stall", data_t'(mem_stb), data_t'(1));
                check_value("o_mem_we under stall", data_t'(mem_we), data_t'(held_we));
                check_value("o_mem_addr under stall", data_t'(mem_addr), data_t'(held_addr));
                check_value("o_mem_wdata under stall", mem_wdata, held_wdata);
            end
            held       = mem_stb && mem_stall;
            held_we    = mem_we;
            held_addr  = mem_addr;
            held_wdata = mem_wdata;

            if (mem_stb && !mem_stall) begin
                if (xfer_q.size() == 0) begin
                    stop_on_error("memory request issued without an accepted input request");
                end
                head = xfer_q.pop_front();
                check_value("o_mem_we", data_t'(mem_we), data_t'(head.we));
                check_value("o_mem_addr", data_t'(mem_addr), data_t'(head.addr));
                if (head.we) begin
                    check_value("o_mem_wdata", mem_wdata, head.data);
                end
                ack_q.push_back(head);
            end

            aud_strobe_exp = 1'b0;
            vid_strobe_exp = 1'b0;
            if (mem_ack) begin
                if (ack_q.size() == 0) begin
                    stop_on_error("memory ack arrived with no request outstanding");
                end
                head = ack_q.pop_front();
                aud_strobe_exp = !head.we && head.src == src_audio;
                vid_strobe_exp = !head.we && head.src == src_video;
                if (head.we && head.last) begin
                    lc_exp = 1'b1;   // sticky from the next edge on
                end
            end
            if (ack_q.size() > max_outstanding) begin
                stop_on_error("more memory requests in flight than max_outstanding allows");
            end

            // input handshakes feed the model
            if (wr_valid && wr_ready) begin
                shadow[wr_addr] = wr_data;
                xfer_q.push_back('{we: 1'b1, src: src_write, addr: wr_addr, data: wr_data,
                                   last: wr_last});
            end
            if (aud_valid && aud_ready) begin
                aud_exp_q.push_back(shadow[aud_addr]);
                xfer_q.push_back('{we: 1'b0, src: src_audio, addr: aud_addr, data: '0,
                                   last: 1'b0});
            end
            if (vid_valid && vid_ready) begin
                vid_exp_q.push_back(shadow[vid_addr]);
                xfer_q.push_back('{we: 1'b0, src: src_video, addr: vid_addr, data: '0,
                                   last: 1'b0});
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(67485));
        rst_dram_ctrl  = 1'b1;
        wr_valid       = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        wr_last        = 1'b0;
        aud_valid      = 1'b0;
        aud_addr       = '0;
        vid_valid      = 1'b0;
        vid_addr       = '0;
        lc_exp         = 1'b0;
        aud_strobe_exp = 1'b0;
        vid_strobe_exp = 1'b0;
        held           = 1'b0;
        repeat (2) @(posedge clk_dram_ctrl);
        @(negedge clk_dram_ctrl);
        rst_dram_ctrl = 1'b0;

        check_value("o_mem_stb", data_t'(mem_stb), '0);
        check_value("o_audio_valid", data_t'(audio_valid), '0);
        check_value("o_video_valid", data_t'(video_valid), '0);
        check_value("o_sample_load_complete", data_t'(load_complete), '0);
        check_value("o_wr_ready", data_t'(wr_ready), '0);
        check_value("o_aud_ready", data_t'(aud_ready), '0);
        check_value("o_vid_ready", data_t'(vid_ready), '0);

        repeat ($urandom_range(16, 8)) burst_addr.push_back(addr_t'($urandom));

        // read streams start at once and must wait for the sample load
        fork
            begin
                foreach (burst_addr[i]) begin
                    pause_random();
                    send_request(src_write, burst_addr[i], random_word(),
                                 i == burst_addr.size() - 1);
                end
                repeat (n_extra_writes) begin
                    pause_random();
                    send_request(src_write, pick_addr(), random_word(), 1'b0);
                end
            end
            begin
                repeat (n_reads) begin
                    pause_random();
                    send_request(src_audio, pick_addr(), '0, 1'b0);
                end
            end
            begin
                repeat (n_reads) begin
                    pause_random();
                    send_request(src_video, pick_addr(), '0, 1'b0);
                end
            end
        join

        waited = 0;
        while (xfer_q.size() != 0 || ack_q.size() != 0 || aud_exp_q.size() != 0 ||
               vid_exp_q.size() != 0) begin
            @(negedge clk_dram_ctrl);
            waited++;
            if (waited > drain_timeout) begin
                stop_on_error("requests still outstanding after the drain timeout");
            end
        end
        check_value("o_sample_load_complete", data_t'(load_complete), data_t'(1));
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* tb/tb_wb_memory.sv */
module tb_wb_memory (
    input  wire                       i_clk_dram_ctrl,
    input  wire                       i_rst_dram_ctrl,
    input  wire                       i_stb,
    input  wire                       i_we,
    input  wire dram_ctrl_pkg::addr_t i_addr,
    input  wire dram_ctrl_pkg::data_t i_wdata,
    output logic                      o_stall,
    output logic                      o_ack,
    output dram_ctrl_pkg::data_t      o_rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import dram_ctrl_pkg::*;

    data_t words [addr_t];
    data_t resp_q [$];   // read data, zero for writes, in issue order
    int    due_q [$];    // first cycle in which each ack may go out
    int    cycle;

    // contents of a word never written
    function automatic data_t fill_word(addr_t a);
        return {8'ha5, a, 8'h5a, ~a, a ^ 24'h3c3c3c, 8'hc3, ~a ^ 24'h0f0f0f, 8'h96};
    endfunction

    initial begin
        o_stall = 1'b0;
        o_ack   = 1'b0;
        o_rdata = '0;
        cycle   = 0;
    end

    // requests are taken on the rising edge
    always @(posedge i_clk_dram_ctrl) begin
        cycle = cycle + 1;
        if (i_rst_dram_ctrl) begin
            resp_q.delete();
            due_q.delete();
        end else if (i_stb && !o_stall) begin
            if (i_we) begin
                words[i_addr] = i_wdata;
                resp_q.push_back('0);
            end else if (words.exists(i_addr)) begin
                resp_q.push_back(words[i_addr]);
            end else begin
                resp_q.push_back(fill_word(i_addr));
            end
            due_q.push_back(cycle + $urandom_range(3, 0));   // 1 to 4 cycles later
        end
    end

    // acks and stall change on the falling edge, one ack per cycle
    always @(negedge i_clk_dram_ctrl) begin
        o_ack = 1'b0;
        if (!i_rst_dram_ctrl && due_q.size() > 0 && due_q[0] <= cycle) begin
            o_ack   = 1'b1;
            o_rdata = resp_q.pop_front();
            void'(due_q.pop_front());
        end
        o_stall = !i_rst_dram_ctrl && ($urandom_range(3, 0) == 0);   // about one in four
    end

endmodule

/* traffic/traffic_decode.sv */
module traffic_decode (
    input  wire                   i_clk_dram_ctrl,
    input  wire                   i_rst_dram_ctrl,

    // sample write stream
    input  wire                   i_wr_valid,
    output logic                  o_wr_ready,
    input  wire dram_ctrl_pkg::addr_t i_wr_addr,
    input  wire dram_ctrl_pkg::data_t i_wr_data,
    input  wire                   i_wr_last,

    // audio read addresses
    input  wire                   i_aud_valid,
    output logic                  o_aud_ready,
    input  wire dram_ctrl_pkg::addr_t i_aud_addr,

    // video read addresses
    input  wire                   i_vid_valid,
    output logic                  o_vid_ready,
    input  wire dram_ctrl_pkg::addr_t i_vid_addr,

    input  wire                   i_sample_load_complete,

    mem_issue_if.producer         issue
);
    import dram_ctrl_pkg::*;

    logic     hold_valid;
    mem_req_t hold_req;
    mem_req_t next_req;
    logic     can_load;
    logic     gnt_wr;
    logic     gnt_aud;
    logic     gnt_vid;
    logic     any_gnt;

    // holding register is free or being emptied this cycle
    assign can_load = !hold_valid || issue.ready;

    // reads are locked out until all samples sit in memory
    assign gnt_vid = i_sample_load_complete && i_vid_valid;
    assign gnt_aud = i_sample_load_complete && i_aud_valid && !i_vid_valid;
    assign gnt_wr  = i_wr_valid && !gnt_vid && !gnt_aud;
    assign any_gnt = gnt_vid || gnt_aud || gnt_wr;

    assign o_vid_ready = can_load && gnt_vid;
    assign o_aud_ready = can_load && gnt_aud;
    assign o_wr_ready  = can_load && gnt_wr;

    // pack the winner
    always_comb begin
        next_req = '{we: 1'b1, src: src_write, addr: i_wr_addr, data: i_wr_data,
                     last: i_wr_last};
        if (gnt_vid) begin
            next_req = '{we: 1'b0, src: src_video, addr: i_vid_addr, data: '0, last: 1'b0};
        end else if (gnt_aud) begin
            next_req = '{we: 1'b0, src: src_audio, addr: i_aud_addr, data: '0, last: 1'b0};
        end
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            hold_valid <= 1'b0;
        end else if (can_load) begin
            hold_valid <= any_gnt;
        end
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (can_load && any_gnt) begin
            hold_req <= next_req;   // granted request
        end
    end

    assign issue.valid = hold_valid;
    assign issue.req   = hold_req;

endmodule

/* traffic/traffic_execute.sv */
module traffic_execute #(
    parameter int max_outstanding = dram_ctrl_pkg::default_max_outstanding
) (
    input  wire                   i_clk_dram_ctrl,
    input  wire                   i_rst_dram_ctrl,

    mem_issue_if.consumer         issue,

    // pipelined wishbone request side
    output logic                  o_mem_stb,
    output logic                  o_mem_we,
    output dram_ctrl_pkg::addr_t  o_mem_addr,
    output dram_ctrl_pkg::data_t  o_mem_wdata,
    input  wire                   i_mem_stall,

    // one pulse per request taken by the bus
    output logic                  o_issue_push,
    output dram_ctrl_pkg::src_t   o_issue_src,
    output logic                  o_issue_last
);
    import dram_ctrl_pkg::*;

    logic     stb_q;
    mem_req_t req_q;
    logic     take;
    logic     bus_accept;

    // the result queue indexes by wrapping pointers
    if (max_outstanding < 1 || (max_outstanding & (max_outstanding - 1)) != 0) begin : g_depth
        $error("traffic_execute: max_outstanding must be a power of two");
    end

    assign bus_accept = stb_q && !i_mem_stall;

    // a new request may follow straight behind one the bus takes now
    assign issue.ready = (!stb_q || !i_mem_stall) && !issue.full;
    assign take        = issue.valid && issue.ready;

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            stb_q <= 1'b0;
        end else if (take) begin
            stb_q <= 1'b1;
        end else if (!i_mem_stall) begin
            stb_q <= 1'b0;   // taken, nothing behind it
        end
    end

    // fields frozen while stalled since take needs the bus free
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (take) begin
            req_q <= issue.req;
        end
    end

    assign o_mem_stb   = stb_q;
    assign o_mem_we    = req_q.we;
    assign o_mem_addr  = req_q.addr;
    assign o_mem_wdata = req_q.data;

    // source and last flag go to the outstanding queue
    assign o_issue_push = bus_accept;
    assign o_issue_src  = req_q.src;
    assign o_issue_last = req_q.last;

endmodule

/* traffic/traffic_result.sv */
module traffic_result #(
    parameter int max_outstanding = dram_ctrl_pkg::default_max_outstanding
) (
    input  wire                   i_clk_dram_ctrl,
    input  wire                   i_rst_dram_ctrl,

    input  wire                   i_issue_push,
    input  wire dram_ctrl_pkg::src_t i_issue_src,
    input  wire                   i_issue_last,

    input  wire                   i_mem_ack,
    input  wire dram_ctrl_pkg::data_t i_mem_rdata,

    mem_issue_if.status           issue,

    output logic                  o_audio_valid,
    output dram_ctrl_pkg::data_t  o_audio_data,
    output logic                  o_video_valid,
    output dram_ctrl_pkg::data_t  o_video_data,
    output logic                  o_sample_load_complete
);
    import dram_ctrl_pkg::*;

    localparam int ptr_w = (max_outstanding > 1) ? $clog2(max_outstanding) : 1;
    localparam logic [ptr_w:0] depth = (ptr_w + 1)'(max_outstanding);

    src_t             src_mem  [1 << ptr_w];
    logic             last_mem [1 << ptr_w];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic [ptr_w:0]   count_next;
    src_t             head_src;
    logic             head_last;

    assign head_src  = src_mem[rd_ptr];
    assign head_last = last_mem[rd_ptr];

    // occupancy after this cycle's push and ack
    assign count_next = count + (ptr_w + 1)'(i_issue_push) - (ptr_w + 1)'(i_mem_ack);
    assign issue.full = count_next >= depth;

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_issue_push) wr_ptr <= wr_ptr + 1'b1;
            if (i_mem_ack) rd_ptr <= rd_ptr + 1'b1;   // acks come back in issue order
            count <= count_next;
        end
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_issue_push) begin
            src_mem[wr_ptr]  <= i_issue_src;
            last_mem[wr_ptr] <= i_issue_last;
        end
    end

    // route the response by the head entry
    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_rst_dram_ctrl) begin
            o_audio_valid          <= 1'b0;
            o_video_valid          <= 1'b0;
            o_sample_load_complete <= 1'b0;
        end else begin
            o_audio_valid <= i_mem_ack && (head_src == src_audio);
            o_video_valid <= i_mem_ack && (head_src == src_video);
            if (i_mem_ack && head_src == src_write && head_last) begin
                o_sample_load_complete <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge i_clk_dram_ctrl) begin
        if (i_mem_ack && head_src == src_audio) o_audio_data <= i_mem_rdata;
        if (i_mem_ack && head_src == src_video) o_video_data <= i_mem_rdata;
    end

endmodule

/* verilog/traffic_generator.sv */
module traffic_generator #(
    parameter int max_outstanding = dram_ctrl_pkg::default_max_outstanding
) (
    input  wire                   i_clk_dram_ctrl,
    input  wire                   i_rst_dram_ctrl,

    // sample write stream
    input  wire                   i_wr_valid,
    output logic                  o_wr_ready,
    input  wire dram_ctrl_pkg::addr_t i_wr_addr,
    input  wire dram_ctrl_pkg::data_t i_wr_data,
    input  wire                   i_wr_last,

    // audio read stream
    input  wire                   i_aud_valid,
    output logic                  o_aud_ready,
    input  wire dram_ctrl_pkg::addr_t i_aud_addr,

    // video read stream
    input  wire                   i_vid_valid,
    output logic                  o_vid_ready,
    input  wire dram_ctrl_pkg::addr_t i_vid_addr,

    // memory bus
    output logic                  o_mem_stb,
    output logic                  o_mem_we,
    output dram_ctrl_pkg::addr_t  o_mem_addr,
    output dram_ctrl_pkg::data_t  o_mem_wdata,
    input  wire                   i_mem_stall,
    input  wire                   i_mem_ack,
    input  wire dram_ctrl_pkg::data_t i_mem_rdata,

    // read responses, no back-pressure
    output logic                  o_audio_valid,
    output dram_ctrl_pkg::data_t  o_audio_data,
    output logic                  o_video_valid,
    output dram_ctrl_pkg::data_t  o_video_data,

    output logic                  o_sample_load_complete
);
    import dram_ctrl_pkg::*;

    logic issue_push;
    src_t issue_src;
    logic issue_last;

    mem_issue_if issue_if ();

    traffic_decode u_decode (
        .i_clk_dram_ctrl        (i_clk_dram_ctrl),
        .i_rst_dram_ctrl        (i_rst_dram_ctrl),
        .i_wr_valid             (i_wr_valid),
        .o_wr_ready             (o_wr_ready),
        .i_wr_addr              (i_wr_addr),
        .i_wr_data              (i_wr_data),
        .i_wr_last              (i_wr_last),
        .i_aud_valid            (i_aud_valid),
        .o_aud_ready            (o_aud_ready),
        .i_aud_addr             (i_aud_addr),
        .i_vid_valid            (i_vid_valid),
        .o_vid_ready            (o_vid_ready),
        .i_vid_addr             (i_vid_addr),
        .i_sample_load_complete (o_sample_load_complete),   // gates the read streams
        .issue                  (issue_if)
    );

    traffic_execute #(
        .max_outstanding (max_outstanding)
    ) u_execute (
        .i_clk_dram_ctrl (i_clk_dram_ctrl),
        .i_rst_dram_ctrl (i_rst_dram_ctrl),
        .issue           (issue_if),
        .o_mem_stb       (o_mem_stb),
        .o_mem_we        (o_mem_we),
        .o_mem_addr      (o_mem_addr),
        .o_mem_wdata     (o_mem_wdata),
        .i_mem_stall     (i_mem_stall),
        .o_issue_push    (issue_push),
        .o_issue_src     (issue_src),
        .o_issue_last    (issue_last)
    );

    traffic_result #(
        .max_outstanding (max_outstanding)
    ) u_result (
        .i_clk_dram_ctrl        (i_clk_dram_ctrl),
        .i_rst_dram_ctrl        (i_rst_dram_ctrl),
        .i_issue_push           (issue_push),
        .i_issue_src            (issue_src),
        .i_issue_last           (issue_last),
        .i_mem_ack              (i_mem_ack),
        .i_mem_rdata            (i_mem_rdata),
        .issue                  (issue_if),
        .o_audio_valid          (o_audio_valid),
        .o_audio_data           (o_audio_data),
        .o_video_valid          (o_video_valid),
        .o_video_data           (o_video_data),
        .o_sample_load_complete (o_sample_load_complete)
    );

endmodule
